/* Bender.yml */
package:
  name: schmidl_cox

sources:
  - sc_pkg.sv
  - sc_stream_if.sv
  - sc_delay_line.sv
  - sc_moving_sum.sv
  - sc_autocorr.sv
  - sc_plateau_detector.sv
  - schmidl_cox.sv
  - target: simulation
    files:
      - schmidl_cox_checker.sv
      - tb_schmidl_cox.sv

/* sc_autocorr.sv */
// Delayed autocorrelation and window energy
// Emits each sample with its window sums P and R, three stages in lockstep
`timescale 1ns/1ps
`default_nettype none

module sc_autocorr #(
  parameter int WINDOW_LEN = 16
) (
  input  logic        clk,
  input  logic        i_reset,
  sc_stream_if.sink   s,
  sc_stream_if.source m
);
  import sc_pkg::*;

  logic                            advance; // Low freezes every stage
  logic                            dl_valid;
  sample_t                         dl_cur;
  sample_t                         dl_old;
  logic                            prod_valid;
  sample_t                         prod_sample;
  logic signed [31:0]              prod_p_i;
  logic signed [31:0]              prod_p_q;
  logic signed [32:0]              prod_r;
  logic                            sum_en;
  logic                            sum_valid;
  sample_t                         sum_sample;
  logic signed [32+SUM_GROWTH-1:0] p_i_sum;
  logic signed [32+SUM_GROWTH-1:0] p_q_sum;
  logic signed [33+SUM_GROWTH-1:0] r_sum;

  assign advance = !(sum_valid && !m.ready);
  assign sum_en  = advance && prod_valid;

  sc_delay_line #(.WINDOW_LEN(WINDOW_LEN)) u_delay (
    .clk(clk), .i_reset(i_reset),
    .s(s),
    .o_cur(dl_cur), .o_old(dl_old), .o_valid(dl_valid), .i_ready(advance)
  );

  always_ff @(posedge clk) begin
    if (i_reset) begin
      prod_valid <= 1'b0;
      sum_valid  <= 1'b0;
    end else if (advance) begin
      prod_valid <= dl_valid;
      sum_valid  <= prod_valid;
    end
  end

  // old * conj(cur) and |cur|^2
  always_ff @(posedge clk) begin
    if (advance && dl_valid) begin
      prod_sample <= dl_cur;
      prod_p_i    <= dl_old.i * dl_cur.i + dl_old.q * dl_cur.q;
      prod_p_q    <= dl_old.q * dl_cur.i - dl_old.i * dl_cur.q;
      prod_r      <= dl_cur.i * dl_cur.i + dl_cur.q * dl_cur.q;
    end
  end

  always_ff @(posedge clk) begin
    if (sum_en)
      sum_sample <= prod_sample; // Lines up with the registered sums
  end

  sc_moving_sum #(.WIDTH(32), .WINDOW_LEN(WINDOW_LEN)) u_sum_p_i (
    .clk(clk), .i_reset(i_reset), .i_en(sum_en), .i_value(prod_p_i), .o_sum(p_i_sum)
  );

  sc_moving_sum #(.WIDTH(32), .WINDOW_LEN(WINDOW_LEN)) u_sum_p_q (
    .clk(clk), .i_reset(i_reset), .i_en(sum_en), .i_value(prod_p_q), .o_sum(p_q_sum)
  );

  // One extra bit keeps 2^31 energy terms positive
  sc_moving_sum #(.WIDTH(33), .WINDOW_LEN(WINDOW_LEN)) u_sum_r (
    .clk(clk), .i_reset(i_reset), .i_en(sum_en), .i_value(prod_r), .o_sum(r_sum)
  );

  assign m.valid       = sum_valid;
  assign m.data.sample = sum_sample;
  assign m.data.corr.i = p_i_sum;
  assign m.data.corr.q = p_q_sum;
  assign m.data.energy = r_sum[$bits(energy_t)-1:0]; // Sum is never negative

endmodule

`default_nettype wire

/* sc_delay_line.sv */
// Sample delay line
// Pairs each accepted sample with the one accepted WINDOW_LEN transfers earlier
`timescale 1ns/1ps
`default_nettype none

module sc_delay_line #(
  parameter int WINDOW_LEN = 16
) (
  input  logic            clk,
  input  logic            i_reset,
  sc_stream_if.sink       s,
  output sc_pkg::sample_t o_cur,
  output sc_pkg::sample_t o_old,
  output logic            o_valid,
  input  logic            i_ready
);
  import sc_pkg::*;

  localparam int PTR_W = $clog2(WINDOW_LEN);

  sample_t            hist [WINDOW_LEN];
  logic [PTR_W-1:0]   wr_ptr;
  logic               filled; // Buffer has wrapped once
  logic               accept;

  assign s.ready = i_ready;
  assign accept  = s.valid && i_ready;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
      wr_ptr  <= '0;
      filled  <= 1'b0;
    end else if (i_ready) begin
      o_valid <= s.valid;
      if (s.valid) begin
        if (wr_ptr == PTR_W'(WINDOW_LEN - 1)) begin
          wr_ptr <= '0;
          filled <= 1'b1;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
    end
  end

  // Oldest entry is read before it is overwritten
  always_ff @(posedge clk) begin
    if (accept) begin
      hist[wr_ptr] <= s.data;
      o_cur        <= s.data;
      o_old        <= filled ? hist[wr_ptr] : '0;
    end
  end

endmodule

`default_nettype wire

/* sc_moving_sum.sv */
// Windowed running sum
// Adds the new value and drops the one leaving a WINDOW_LEN entry window
`timescale 1ns/1ps
`default_nettype none

module sc_moving_sum #(
  parameter int WIDTH      = 32,
  parameter int WINDOW_LEN = 16
) (
  input  logic                                    clk,
  input  logic                                    i_reset,
  input  logic                                    i_en,
  input  logic signed [WIDTH-1:0]                 i_value,
  output logic signed [WIDTH+sc_pkg::SUM_GROWTH-1:0] o_sum
);

  localparam int PTR_W = $clog2(WINDOW_LEN);

  logic signed [WIDTH-1:0] hist [WINDOW_LEN];
  logic [PTR_W-1:0]        ptr;
  logic                    filled;
  logic signed [WIDTH-1:0] leaving;

  // Entries not yet written count as zero
  assign leaving = filled ? hist[ptr] : '0;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_sum  <= '0;
      ptr    <= '0;
      filled <= 1'b0;
    end else if (i_en) begin
      o_sum <= o_sum + i_value - leaving;
      if (ptr == PTR_W'(WINDOW_LEN - 1)) begin
        ptr    <= '0;
        filled <= 1'b1;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_en)
      hist[ptr] <= i_value;
  end

endmodule

`default_nettype wire

/* sc_pkg.sv */
// Schmidl-Cox synchronizer shared types
// Sample, correlation and energy formats, settings map and magnitude helper
`default_nettype none

package sc_pkg;

  localparam int MAX_WINDOW = 64;
  localparam int SUM_GROWTH = $clog2(MAX_WINDOW); // Bits added by a full window sum
  localparam int CORR_W     = 32 + SUM_GROWTH;

  typedef struct packed {
    logic signed [15:0] i;
    logic signed [15:0] q;
  } sample_t;

  typedef struct packed {
    logic signed [CORR_W-1:0] i;
    logic signed [CORR_W-1:0] q;
  } corr_t;

  typedef logic [CORR_W-1:0] energy_t;

  typedef struct packed {
    sample_t sample;
    corr_t   corr;
    energy_t energy;
  } sc_result_t;

  localparam logic [7:0] ADDR_THRESHOLD  = 8'd0;
  localparam logic [7:0] ADDR_PLATEAU    = 8'd1;
  localparam logic [7:0] THRESHOLD_RESET = 8'd160; // ~0.625 in Q0.8
  localparam logic [7:0] PLATEAU_RESET   = 8'd16;

  // max(|I|,|Q|) + min(|I|,|Q|)/2, never above 1.5 * 2^37
  function automatic logic [CORR_W-1:0] mag_approx(corr_t c);
    logic [CORR_W-1:0] abs_i;
    logic [CORR_W-1:0] abs_q;
    abs_i = c.i[CORR_W-1] ? -c.i : c.i; // -2^37 maps to 2^37 unsigned
    abs_q = c.q[CORR_W-1] ? -c.q : c.q;
    if (abs_i >= abs_q)
      return abs_i + (abs_q >> 1);
    return abs_q + (abs_i >> 1);
  endfunction

endpackage

`default_nettype wire

/* sc_plateau_detector.sv */
// Plateau detector and output stage
// Compares |P| against threshold * R and tags the start-of-frame sample
`timescale 1ns/1ps
`default_nettype none

module sc_plateau_detector (
  input  logic            clk,
  input  logic            i_reset,
  input  logic            i_set_stb,
  input  logic [7:0]      i_set_addr,
  input  logic [31:0]     i_set_data,
  sc_stream_if.sink       s,
  output sc_pkg::sample_t o_tdata,
  output logic            o_sof,
  output logic            o_tvalid,
  input  logic            i_tready
);
  import sc_pkg::*;

  localparam int CMP_W = $bits(energy_t) + 8;

  logic [7:0]       threshold;   // Q0.8
  logic [7:0]       plateau_len;
  logic [7:0]       plateau_cnt;
  logic [7:0]       cnt_next;
  logic             armed;
  logic             accept;
  logic             above;
  logic             hit;
  logic [CMP_W-1:0] metric_lhs;
  logic [CMP_W-1:0] metric_rhs;

  assign s.ready = !o_tvalid || i_tready;
  assign accept  = s.valid && s.ready;

  // 256 * |P| >= threshold * R, without a divider
  assign metric_lhs = {mag_approx(s.data.corr), 8'd0};
  assign metric_rhs = threshold * s.data.energy;
  assign above      = (s.data.energy != '0) && (metric_lhs >= metric_rhs);

  // Saturate so a long plateau cannot wrap back onto the target
  assign cnt_next = !above ? 8'd0 :
                    (plateau_cnt == 8'hff) ? plateau_cnt : plateau_cnt + 8'd1;
  assign hit      = armed && above && (cnt_next == plateau_len);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      threshold   <= THRESHOLD_RESET;
      plateau_len <= PLATEAU_RESET;
    end else if (i_set_stb) begin
      case (i_set_addr)
        ADDR_THRESHOLD: threshold   <= i_set_data[7:0];
        ADDR_PLATEAU:   plateau_len <= i_set_data[7:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      plateau_cnt <= 8'd0;
      armed       <= 1'b1;
    end else if (accept) begin
      plateau_cnt <= cnt_next;
      if (hit)
        armed <= 1'b0;  // Quiet until the metric drops
      else if (!above)
        armed <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_tvalid <= 1'b0;
      o_sof    <= 1'b0;
    end else if (accept) begin
      o_tvalid <= 1'b1;
      o_sof    <= hit;
    end else if (i_tready) begin
      o_tvalid <= 1'b0;
      o_sof    <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept)
      o_tdata <= s.data.sample;
  end

endmodule

`default_nettype wire

/* sc_stream_if.sv */
// Valid/ready stream between synchronizer stages
// A transfer happens on a clock edge where valid and ready are both high
`timescale 1ns/1ps
`default_nettype none

interface sc_stream_if #(
  parameter type payload_t = sc_pkg::sample_t
);

  payload_t data;
  logic     valid;
  logic     ready; // May depend on valid

  // Source holds data steady from valid until the transfer
  modport source (
    output data,
    output valid,
    input  ready
  );

  modport sink (
    input  data,
    input  valid,
    output ready
  );

endinterface

`default_nettype wire

/* schmidl_cox.f */
sc_pkg.sv
sc_stream_if.sv
sc_delay_line.sv
sc_moving_sum.sv
sc_autocorr.sv
sc_plateau_detector.sv
schmidl_cox.sv
schmidl_cox_checker.sv
tb_schmidl_cox.sv

/* schmidl_cox.sv */
// Schmidl-Cox timing synchronizer
// Autocorrelation over WINDOW_LEN samples followed by plateau detection
`timescale 1ns/1ps
`default_nettype none

module schmidl_cox #(
  parameter int WINDOW_LEN = 16
) (
  input  logic            clk,
  input  logic            i_reset,
  // Settings bus
  input  logic            i_set_stb,
  input  logic [7:0]      i_set_addr,
  input  logic [31:0]     i_set_data,
  // Input samples
  input  sc_pkg::sample_t i_tdata,
  input  logic            i_tvalid,
  output logic            o_tready,
  // Output samples, tagged with start of frame
  output sc_pkg::sample_t o_tdata,
  output logic            o_sof,
  output logic            o_tvalid,
  input  logic            i_tready
);
  import sc_pkg::*;

  if (WINDOW_LEN < 8 || WINDOW_LEN > MAX_WINDOW) begin : g_bad_window
    $error("WINDOW_LEN %0d outside 8..%0d", WINDOW_LEN, MAX_WINDOW);
  end

  sc_stream_if #(.payload_t(sample_t))    in_s ();
  sc_stream_if #(.payload_t(sc_result_t)) res_s ();

  assign in_s.data  = i_tdata;
  assign in_s.valid = i_tvalid;
  assign o_tready   = in_s.ready; // Stall reaches here in the same cycle

  sc_autocorr #(.WINDOW_LEN(WINDOW_LEN)) u_autocorr (
    .clk(clk),
    .i_reset(i_reset),
    .s(in_s),
    .m(res_s)
  );

  sc_plateau_detector u_detector (
    .clk(clk),
    .i_reset(i_reset),
    .i_set_stb(i_set_stb),
    .i_set_addr(i_set_addr),
    .i_set_data(i_set_data),
    .s(res_s),
    .o_tdata(o_tdata),
    .o_sof(o_sof),
    .o_tvalid(o_tvalid),
    .i_tready(i_tready)
  );

endmodule

`default_nettype wire

/* schmidl_cox_checker.sv */
// Output stream checker for the synchronizer
// Bound to the top level, watches the handshake and the reset state
`timescale 1ns/1ps
`default_nettype none

module schmidl_cox_checker (
  input logic            clk,
  input logic            i_reset,
  input sc_pkg::sample_t o_tdata,
  input logic            o_sof,
  input logic            o_tvalid,
  input logic            i_tready
);

  int fail_count = 0;

  // A stalled output holds its sample and flag
  a_stall_hold: assert property (@(posedge clk) disable iff (i_reset)
      (o_tvalid && !i_tready) |=> (o_tvalid && $stable(o_tdata) && $stable(o_sof)))
    else begin
      fail_count++;
      $error("Output changed while stalled");
    end

  a_reset_idle: assert property (@(posedge clk) i_reset |=> (!o_tvalid && !o_sof))
    else begin
      fail_count++;
      $error("Output valid right after reset");
    end

  a_sof_valid: assert property (@(posedge clk) o_sof |-> o_tvalid)
    else begin
      fail_count++;
      $error("Start of frame without valid");
    end

endmodule

`default_nettype wire

/* schmidl_cox_stim.txt */
# W addr data_hex: settings write.  T name ready_mode(0 high, 1 random) sample_count
# S noise_len preamble_amp zero_len: 32 preamble samples unless amp is 0.  E sof_index
W 0 96
T passthru 0 40
S 40 0 0
T preamble 0 76
S 20 4096 24
E 60
T noise_only 0 48
S 48 0 0
W 1 14
T plateau_20 0 76
S 20 4096 24
E 64
W 0 ff
T threshold_hi 0 76
S 20 4096 24
W 0 96
T threshold_back 0 76
S 20 4096 24
E 64
W 1 10
T backpressure 1 76
S 20 4096 24
E 60

/* tb_schmidl_cox.sv */
// Testbench for the Schmidl-Cox synchronizer
// Replays the stimulus file and scores output data and start-of-frame flags
`timescale 1ns/1ps
`default_nettype none

module tb_schmidl_cox;
  import sc_pkg::*;

  localparam int    WINDOW_LEN   = 16;
  localparam int    PREAMBLE_LEN = 2 * WINDOW_LEN;
  localparam string STIM_FILE    = "schmidl_cox_stim.txt";

  logic        clk;
  logic        i_reset;
  logic        i_set_stb;
  logic [7:0]  i_set_addr;
  logic [31:0] i_set_data;
  sample_t     i_tdata;
  logic        i_tvalid;
  logic        o_tready;
  sample_t     o_tdata;
  logic        o_sof;
  logic        o_tvalid;
  logic        i_tready;

  // Parsed stimulus
  string t_name[$];
  int    t_mode[$];   // 0 ready held high, 1 random ready
  int    t_count[$];
  int    t_noise[$];
  int    t_amp[$];
  int    t_zeros[$];
  int    w_test[$];   // Write goes out before this test
  int    w_addr[$];
  int    w_data[$];
  int    e_test[$];
  int    e_idx[$];

  sample_t exp_q[$];
  int      sof_idx[$];
  int      seed = 32'h24bf_41d6;
  int      gen_idx = 0;  // Global sample count keeps the noise pattern continuous
  int      stim_errors = 0;
  int      tests_passed = 0;
  int      tests_failed = 0;
  int      cycle_count = 0;
  int      cycle_limit = 0;

  schmidl_cox #(.WINDOW_LEN(WINDOW_LEN)) dut (
    .clk(clk), .i_reset(i_reset),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_tdata(i_tdata), .i_tvalid(i_tvalid), .o_tready(o_tready),
    .o_tdata(o_tdata), .o_sof(o_sof), .o_tvalid(o_tvalid), .i_tready(i_tready)
  );

  bind schmidl_cox schmidl_cox_checker u_checker (
    .clk(clk), .i_reset(i_reset), .o_tdata(o_tdata), .o_sof(o_sof),
    .o_tvalid(o_tvalid), .i_tready(i_tready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  // Period 32 sign pattern so products one window apart alternate and cancel
  function automatic sample_t pseudo_noise(int g);
    sample_t s;
    if (g % 2 == 0)
      s.i = 16'sd4;
    else
      s.i = ((g / 16) % 2 == 1) ? -16'sd4 : 16'sd4;
    s.q = -s.i; // Q differs from I on every sample
    return s;
  endfunction

  function automatic sample_t preamble_sample(int k, int amp);
    sample_t s;
    s.q = '0;
    s.i = ((k % WINDOW_LEN) % 3 == 0) ? 16'(-amp) : 16'(amp); // Same in both halves
    return s;
  endfunction

  function automatic logic sof_expected(int idx);
    foreach (sof_idx[j])
      if (sof_idx[j] == idx)
        return 1'b1;
    return 1'b0;
  endfunction

  task automatic compare_sample(input int idx, input sample_t got, input sample_t exp,
                                inout int errs);
    if (got !== exp) begin
      $display("error: %0t sample %0d data %h, expected %h", $time, idx, got, exp);
      errs++;
    end
  endtask

  task automatic compare_sof(input int idx, input logic got, input logic exp, inout int errs);
    if (got !== exp) begin
      $display("error: %0t sample %0d sof %b, expected %b", $time, idx, got, exp);
      errs++;
    end
  endtask

  task automatic read_stim();
    int    fd;
    int    n;
    int    want;
    int    a;
    int    b;
    int    c;
    string line;
    string name;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file %s", STIM_FILE);
      stim_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line[0] == "#")
        continue;
      want = 3;
      case (line[0])
        "W": begin
          want = 2;
          n = $sscanf(line, "W %d %h", a, b);
          w_test.push_back(t_name.size());
          w_addr.push_back(a);
          w_data.push_back(b);
        end
        "T": begin
          n = $sscanf(line, "T %s %d %d", name, a, b);
          t_name.push_back(name);
          t_mode.push_back(a);
          t_count.push_back(b);
        end
        "S": begin
          n = $sscanf(line, "S %d %d %d", a, b, c);
          t_noise.push_back(a);
          t_amp.push_back(b);
          t_zeros.push_back(c);
        end
        "E": begin
          want = 1;
          n = $sscanf(line, "E %d", a);
          e_test.push_back(t_name.size() - 1);
          e_idx.push_back(a);
        end
        default: n = -1;
      endcase
      if (n != want) begin
        $display("Malformed stimulus line: %s", line);
        stim_errors++;
      end
    end
    $fclose(fd);
    if (t_noise.size() != t_name.size()) begin
      $display("Each test needs exactly one sample line");
      stim_errors++;
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    i_set_addr = addr;
    i_set_data = data;
    i_set_stb  = 1'b1;
    @(posedge clk);
    #1;
    i_set_stb  = 1'b0;
  endtask

  task automatic run_test(input int ti);
    sample_t sent[$];
    int      errs;
    int      rx_count;
    int      n_sof;
    int      extra;
    int      rnd;
    logic    fire;
    errs     = 0;
    rx_count = 0;
    n_sof    = 0;
    extra    = 0;
    sof_idx.delete();
    for (int k = 0; k < t_noise[ti]; k++) begin
      sent.push_back(pseudo_noise(gen_idx));
      gen_idx++;
    end
    if (t_amp[ti] != 0) begin
      for (int k = 0; k < PREAMBLE_LEN; k++) begin
        sent.push_back(preamble_sample(k, t_amp[ti]));
        gen_idx++;
      end
    end
    for (int k = 0; k < t_zeros[ti]; k++) begin
      sent.push_back('0);
      gen_idx++;
    end
    foreach (e_test[j])
      if (e_test[j] == ti)
        sof_idx.push_back(e_idx[j]);
    if (sent.size() != t_count[ti]) begin
      $display("Test %s builds %0d samples but its header says %0d",
               t_name[ti], sent.size(), t_count[ti]);
      errs++;
    end
    exp_q = sent;
    fork
      begin
        foreach (sent[j]) begin
          i_tdata  = sent[j];
          i_tvalid = 1'b1;
          do begin
            @(negedge clk);
            fire = o_tready;  // Stable between the drive point and the next edge
            @(posedge clk);
            #1;
          end while (!fire);
        end
        i_tvalid = 1'b0;
        i_tdata  = '0;
      end
      begin
        while (rx_count < sent.size()) begin
          @(negedge clk);
          if (o_tvalid && i_tready) begin
            compare_sample(rx_count, o_tdata, exp_q.pop_front(), errs);
            compare_sof(rx_count, o_sof, sof_expected(rx_count), errs);
            if (o_sof)
              n_sof++;
            rx_count++;
          end
          @(posedge clk);
          #1;
          rnd      = $random(seed);
          i_tready = (t_mode[ti] == 1) ? rnd[0] : 1'b1;
        end
      end
    join
    i_tready = 1'b1;
    repeat (8) begin
      @(negedge clk);
      if (o_tvalid)
        extra++;
      @(posedge clk);
      #1;
    end
    if (extra != 0) begin
      $display("Test %s: the DUT sent more samples than it received", t_name[ti]);
      errs++;
    end
    if (errs == 0)
      tests_passed++;
    else
      tests_failed++;
    $display("Test %s %s  %0d samples, %0d sof, %0d errors",
             t_name[ti], (errs == 0) ? "pass" : "fail", rx_count, n_sof, errs);
  endtask

  initial begin
    int wi;
    int total;
    i_reset    = 1'b1;
    i_set_stb  = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_tdata    = '0;
    i_tvalid   = 1'b0;
    i_tready   = 1'b1;
    $timeformat(-9, 1, " ns", 0);
    read_stim();
    total = 0;
    foreach (t_count[j])
      total += t_count[j];
    cycle_limit = 8 * total + 200;
    repeat (10) @(posedge clk);
    #1;
    i_reset = 1'b0;
    wi = 0;
    for (int ti = 0; ti < t_name.size(); ti++) begin
      while (wi < w_test.size() && w_test[wi] == ti) begin
        write_reg(w_addr[wi], w_data[wi]);
        wi++;
      end
      run_test(ti);
    end
    if (dut.u_checker.fail_count != 0)
      $display("Output checker reported %0d assertion failures", dut.u_checker.fail_count);
    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && stim_errors == 0 && t_name.size() > 0 &&
        dut.u_checker.fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
